// ==== hdl/spec_pkg.sv ====
`default_nettype none

package spec_pkg;

  // ====================================================================
  // datapath widths
  // ====================================================================

  // signed fft real and imaginary parts
  localparam int FFT_W   = 29;
  // bin index of a 4096 point frame
  localparam int BIN_W   = 12;
  // real^2 + imag^2 plus room for the channel b scale
  localparam int POWER_W = 60;
  // synthesizer frequency word
  localparam int FREQ_W  = 24;

  // ====================================================================
  // frame layout and windows
  // ====================================================================

  // only the lower half of each frame is kept
  localparam int HALF_BINS = 2048;
  localparam int BUF_AW    = 11;
  localparam logic [BIN_W-1:0] LAST_BIN = 12'd2047;

  // per-channel peak window, open bounds
  localparam logic [BIN_W-1:0] PEAK_LO = 12'd3;
  localparam logic [BIN_W-1:0] PEAK_HI = 12'd2044;

  // difference window, open bounds
  localparam logic [BIN_W-1:0] DIFF_LO = 12'd10;
  localparam logic [BIN_W-1:0] DIFF_HI = 12'd2037;

  // scanner reads addresses 0 .. SCAN_END-1
  localparam logic [BIN_W-1:0] SCAN_END = 12'd2047;

  // freq word = (index >> FREQ_SHIFT) * FREQ_STEP
  localparam int FREQ_SHIFT = 3;
  localparam logic [FREQ_W-1:0] FREQ_STEP = 24'd65;

  // capture fsm
  localparam logic [1:0] CAP_IDLE    = 2'd0;
  localparam logic [1:0] CAP_COLLECT = 2'd1;
  localparam logic [1:0] CAP_HELD    = 2'd2;

  // scanner fsm
  localparam logic [1:0] SCAN_IDLE   = 2'd0;
  localparam logic [1:0] SCAN_READ   = 2'd1;
  localparam logic [1:0] SCAN_DRAIN  = 2'd2;
  localparam logic [1:0] SCAN_FINISH = 2'd3;

endpackage

`default_nettype wire

// ==== hdl/bin_power.sv ====
`timescale 1ns/1ps
`default_nettype none

module bin_power #(
  // left shift on the power, channel b uses 2
  parameter int POWER_SHIFT = 0
) (
  input  wire                               clk_64m,
  input  wire                               rst,
  input  wire signed [spec_pkg::FFT_W-1:0]  fft_real_i,
  input  wire signed [spec_pkg::FFT_W-1:0]  fft_imag_i,
  input  wire        [spec_pkg::BIN_W-1:0]  fft_index_i,
  input  wire                               fft_valid_i,
  output logic       [spec_pkg::POWER_W-1:0] power_o,
  output logic       [spec_pkg::BIN_W-1:0]  power_index_o,
  output logic                              power_valid_o
);

  // signed squares, never negative
  logic signed [2*spec_pkg::FFT_W-1:0] real_sq;
  logic signed [2*spec_pkg::FFT_W-1:0] imag_sq;
  // zero extended to the power width
  logic [spec_pkg::POWER_W-1:0] real_sq_w;
  logic [spec_pkg::POWER_W-1:0] imag_sq_w;
  logic [spec_pkg::POWER_W-1:0] power_sum;

  assign real_sq = fft_real_i * fft_real_i;
  assign imag_sq = fft_imag_i * fft_imag_i;

  // widen before the add so the carry survives
  assign real_sq_w = {{(spec_pkg::POWER_W - 2*spec_pkg::FFT_W){1'b0}}, real_sq};
  assign imag_sq_w = {{(spec_pkg::POWER_W - 2*spec_pkg::FFT_W){1'b0}}, imag_sq};
  assign power_sum = real_sq_w + imag_sq_w;

  // strobe delayed by one cycle
  always_ff @(posedge clk_64m) begin
    if (rst) begin
      power_valid_o <= 1'b0;
    end else begin
      power_valid_o <= fft_valid_i;
    end
  end

  // power and index captured with the strobe
  // shifted result truncated to POWER_W
  always_ff @(posedge clk_64m) begin
    if (fft_valid_i) begin
      power_o       <= power_sum << POWER_SHIFT;
      power_index_o <= fft_index_i;
    end
  end

  // downstream buffer addressing needs a clean index
  assert property (@(posedge clk_64m) disable iff (rst)
    power_valid_o |-> !$isunknown(power_index_o))
    else $error("bin_power: unknown index with power_valid_o");

endmodule

`default_nettype wire

// ==== hdl/frame_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_capture (
  input  wire                                clk_64m,
  input  wire                                rst,
  input  wire  [spec_pkg::POWER_W-1:0]       power_i,
  input  wire  [spec_pkg::BIN_W-1:0]         power_index_i,
  input  wire                                power_valid_i,
  input  wire                                release_i,
  input  wire  [spec_pkg::BIN_W-1:0]         rd_addr_i,
  output logic [spec_pkg::POWER_W-1:0]       rd_power_o,
  output logic                               frame_done_o,
  output logic [spec_pkg::BIN_W-1:0]         peak_index_o,
  output logic [spec_pkg::POWER_W-1:0]       peak_power_o
);

  logic [1:0] state;

  // running peak of the frame in progress
  logic [spec_pkg::POWER_W-1:0] run_peak;
  logic [spec_pkg::BIN_W-1:0]   run_index;

  // lower half spectrum of one frame
  logic [spec_pkg::POWER_W-1:0] spec_mem [spec_pkg::HALF_BINS];

  logic                         frame_start;
  logic                         in_frame;
  logic                         wr_en;
  logic                         in_window;
  logic                         peak_hit;
  logic                         last_bin;
  logic [spec_pkg::POWER_W-1:0] next_peak;
  logic [spec_pkg::BIN_W-1:0]   next_index;

  // ====================================================================
  // bin qualification
  // ====================================================================

  // first valid bin 0 opens a frame
  assign frame_start = (state == spec_pkg::CAP_IDLE) && power_valid_i &&
                       (power_index_i == '0);

  // upper half bins dropped
  assign in_frame = (state == spec_pkg::CAP_COLLECT) && power_valid_i &&
                    (power_index_i <= spec_pkg::LAST_BIN);

  // bin 0 is stored too
  assign wr_en = frame_start || in_frame;

  // guard window keeps dc and the band edge out
  assign in_window = (power_index_i > spec_pkg::PEAK_LO) &&
                     (power_index_i < spec_pkg::PEAK_HI);

  // strictly greater, first maximum wins
  assign peak_hit   = in_frame && in_window && (power_i > run_peak);
  assign next_peak  = peak_hit ? power_i : run_peak;
  assign next_index = peak_hit ? power_index_i : run_index;

  assign last_bin = in_frame && (power_index_i == spec_pkg::LAST_BIN);

  // ====================================================================
  // frame fsm
  // ====================================================================

  always_ff @(posedge clk_64m) begin
    if (rst) begin
      state        <= spec_pkg::CAP_IDLE;
      frame_done_o <= 1'b0;
      peak_index_o <= '0;
      peak_power_o <= '0;
    end else begin
      case (state)
        spec_pkg::CAP_IDLE: begin
          if (frame_start) begin
            state <= spec_pkg::CAP_COLLECT;
          end
        end
        spec_pkg::CAP_COLLECT: begin
          // last bin still counts toward the peak
          if (last_bin) begin
            state        <= spec_pkg::CAP_HELD;
            frame_done_o <= 1'b1;
            peak_index_o <= next_index;
            peak_power_o <= next_peak;
          end
        end
        spec_pkg::CAP_HELD: begin
          // buffer and peak frozen until the scanner lets go
          if (release_i) begin
            state        <= spec_pkg::CAP_IDLE;
            frame_done_o <= 1'b0;
          end
        end
        default: begin
          state <= spec_pkg::CAP_IDLE;
        end
      endcase
    end
  end

  // running peak, cleared as a frame opens
  always_ff @(posedge clk_64m) begin
    if (frame_start) begin
      run_peak  <= '0;
      run_index <= '0;
    end else if (peak_hit) begin
      run_peak  <= power_i;
      run_index <= power_index_i;
    end
  end

  // ====================================================================
  // spectrum buffer
  // ====================================================================

  // write side from the power stage
  always_ff @(posedge clk_64m) begin
    if (wr_en) begin
      spec_mem[power_index_i[spec_pkg::BUF_AW-1:0]] <= power_i;
    end
  end

  // scanner read, one cycle latency
  always_ff @(posedge clk_64m) begin
    rd_power_o <= spec_mem[rd_addr_i[spec_pkg::BUF_AW-1:0]];
  end

  // scanner only releases a held frame
  assert property (@(posedge clk_64m) disable iff (rst)
    release_i |-> frame_done_o)
    else $error("frame_capture: release_i while frame_done_o is low");

  // done flag and fsm agree
  assert property (@(posedge clk_64m) disable iff (rst)
    (state == spec_pkg::CAP_IDLE) |-> !frame_done_o)
    else $error("frame_capture: frame_done_o high in idle");

endmodule

`default_nettype wire

// ==== hdl/diff_peak_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module diff_peak_scan (
  input  wire                                clk_64m,
  input  wire                                rst,
  input  wire                                done_a_i,
  input  wire                                done_b_i,
  output logic [spec_pkg::BIN_W-1:0]         rd_addr_o,
  input  wire  [spec_pkg::POWER_W-1:0]       power_a_i,
  input  wire  [spec_pkg::POWER_W-1:0]       power_b_i,
  output logic                               release_o,
  output logic [spec_pkg::BIN_W-1:0]         diff_index_o,
  output logic [spec_pkg::POWER_W-1:0]       diff_power_o,
  output logic [spec_pkg::FREQ_W-1:0]        freq_word_o,
  output logic                               result_valid_o
);

  logic [1:0] state;

  // read data pairs with the address of the previous cycle
  logic                         eval_valid;
  logic [spec_pkg::BIN_W-1:0]   eval_index;

  // best positive difference so far
  logic [spec_pkg::POWER_W-1:0] best_diff;
  logic [spec_pkg::BIN_W-1:0]   best_index;

  logic [spec_pkg::POWER_W-1:0] cur_diff;
  logic                         in_window;
  logic                         a_wins;
  logic                         diff_hit;
  logic [spec_pkg::POWER_W-1:0] next_diff;
  logic [spec_pkg::BIN_W-1:0]   next_index;
  logic [spec_pkg::FREQ_W-1:0]  index_wide;
  logic [spec_pkg::FREQ_W-1:0]  freq_next;
  logic                         last_addr;

  // ====================================================================
  // compare
  // ====================================================================

  // only meaningful when a wins
  assign cur_diff  = power_a_i - power_b_i;
  assign a_wins    = power_a_i > power_b_i;
  assign in_window = (eval_index > spec_pkg::DIFF_LO) && (eval_index < spec_pkg::DIFF_HI);

  // strictly greater, lowest index kept on ties
  assign diff_hit   = eval_valid && in_window && a_wins && (cur_diff > best_diff);
  assign next_diff  = diff_hit ? cur_diff : best_diff;
  assign next_index = diff_hit ? eval_index : best_index;

  // synthesizer word from the winning bin
  assign index_wide = {{(spec_pkg::FREQ_W - spec_pkg::BIN_W){1'b0}}, next_index};
  assign freq_next  = (index_wide >> spec_pkg::FREQ_SHIFT) * spec_pkg::FREQ_STEP;

  assign last_addr = (rd_addr_o == (spec_pkg::SCAN_END - 12'd1));

  // address of the data arriving next cycle
  always_ff @(posedge clk_64m) begin
    eval_index <= rd_addr_o;
  end

  // ====================================================================
  // scan fsm
  // ====================================================================

  always_ff @(posedge clk_64m) begin
    if (rst) begin
      state          <= spec_pkg::SCAN_IDLE;
      rd_addr_o      <= '0;
      eval_valid     <= 1'b0;
      best_diff      <= '0;
      best_index     <= '0;
      release_o      <= 1'b0;
      result_valid_o <= 1'b0;
      diff_index_o   <= '0;
      diff_power_o   <= '0;
      freq_word_o    <= '0;
    end else begin
      // single cycle pulses
      release_o      <= 1'b0;
      result_valid_o <= 1'b0;
      eval_valid     <= (state == spec_pkg::SCAN_READ);
      best_diff      <= next_diff;
      best_index     <= next_index;
      case (state)
        spec_pkg::SCAN_IDLE: begin
          // both spectra held
          if (done_a_i && done_b_i) begin
            state     <= spec_pkg::SCAN_READ;
            rd_addr_o <= '0;
          end
        end
        spec_pkg::SCAN_READ: begin
          // one address per cycle
          if (last_addr) begin
            state <= spec_pkg::SCAN_DRAIN;
          end else begin
            rd_addr_o <= rd_addr_o + 12'd1;
          end
        end
        spec_pkg::SCAN_DRAIN: begin
          // last read is being compared now
          diff_index_o   <= next_index;
          diff_power_o   <= next_diff;
          freq_word_o    <= freq_next;
          release_o      <= 1'b1;
          result_valid_o <= 1'b1;
          best_diff      <= '0;
          best_index     <= '0;
          state          <= spec_pkg::SCAN_FINISH;
        end
        spec_pkg::SCAN_FINISH: begin
          // wait for both captures to drop done
          if (!done_a_i && !done_b_i) begin
            state <= spec_pkg::SCAN_IDLE;
          end
        end
        default: begin
          state <= spec_pkg::SCAN_IDLE;
        end
      endcase
    end
  end

  // result and release leave together
  assert property (@(posedge clk_64m) disable iff (rst)
    result_valid_o == release_o)
    else $error("diff_peak_scan: result_valid_o and release_o differ");

  // release never hits a capture that is not holding
  assert property (@(posedge clk_64m) disable iff (rst)
    release_o |-> (done_a_i && done_b_i))
    else $error("diff_peak_scan: release_o without both frames done");

endmodule

`default_nettype wire

// ==== hdl/spectral_diff_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spectral_diff_top (
  input  wire                                clk_64m,
  input  wire                                rst,
  // channel a fft stream
  input  wire signed [spec_pkg::FFT_W-1:0]   fft_real_a_i,
  input  wire signed [spec_pkg::FFT_W-1:0]   fft_imag_a_i,
  input  wire        [spec_pkg::BIN_W-1:0]   fft_index_a_i,
  input  wire                                fft_valid_a_i,
  // channel b fft stream
  input  wire signed [spec_pkg::FFT_W-1:0]   fft_real_b_i,
  input  wire signed [spec_pkg::FFT_W-1:0]   fft_imag_b_i,
  input  wire        [spec_pkg::BIN_W-1:0]   fft_index_b_i,
  input  wire                                fft_valid_b_i,
  // per-channel peaks
  output logic       [spec_pkg::BIN_W-1:0]   peak_index_a_o,
  output logic       [spec_pkg::POWER_W-1:0] peak_power_a_o,
  output logic       [spec_pkg::BIN_W-1:0]   peak_index_b_o,
  output logic       [spec_pkg::POWER_W-1:0] peak_power_b_o,
  // difference result
  output logic       [spec_pkg::BIN_W-1:0]   diff_index_o,
  output logic       [spec_pkg::POWER_W-1:0] diff_power_o,
  output logic       [spec_pkg::FREQ_W-1:0]  freq_word_o,
  output logic                               result_valid_o
);

  // power stage to capture
  logic [spec_pkg::POWER_W-1:0] power_a;
  logic [spec_pkg::BIN_W-1:0]   power_index_a;
  logic                         power_valid_a;
  logic [spec_pkg::POWER_W-1:0] power_b;
  logic [spec_pkg::BIN_W-1:0]   power_index_b;
  logic                         power_valid_b;

  // capture to scanner
  logic [spec_pkg::BIN_W-1:0]   rd_addr;
  logic [spec_pkg::POWER_W-1:0] rd_power_a;
  logic [spec_pkg::POWER_W-1:0] rd_power_b;
  logic                         frame_done_a;
  logic                         frame_done_b;
  logic                         scan_release;

  // ====================================================================
  // channel a, unscaled
  // ====================================================================

  bin_power #(.POWER_SHIFT(0)) u_power_a (
    .clk_64m       (clk_64m),
    .rst           (rst),
    .fft_real_i    (fft_real_a_i),
    .fft_imag_i    (fft_imag_a_i),
    .fft_index_i   (fft_index_a_i),
    .fft_valid_i   (fft_valid_a_i),
    .power_o       (power_a),
    .power_index_o (power_index_a),
    .power_valid_o (power_valid_a)
  );

  frame_capture u_capture_a (
    .clk_64m       (clk_64m),
    .rst           (rst),
    .power_i       (power_a),
    .power_index_i (power_index_a),
    .power_valid_i (power_valid_a),
    .release_i     (scan_release),
    .rd_addr_i     (rd_addr),
    .rd_power_o    (rd_power_a),
    .frame_done_o  (frame_done_a),
    .peak_index_o  (peak_index_a_o),
    .peak_power_o  (peak_power_a_o)
  );

  // ====================================================================
  // channel b, power times four
  // ====================================================================

  bin_power #(.POWER_SHIFT(2)) u_power_b (
    .clk_64m       (clk_64m),
    .rst           (rst),
    .fft_real_i    (fft_real_b_i),
    .fft_imag_i    (fft_imag_b_i),
    .fft_index_i   (fft_index_b_i),
    .fft_valid_i   (fft_valid_b_i),
    .power_o       (power_b),
    .power_index_o (power_index_b),
    .power_valid_o (power_valid_b)
  );

  frame_capture u_capture_b (
    .clk_64m       (clk_64m),
    .rst           (rst),
    .power_i       (power_b),
    .power_index_i (power_index_b),
    .power_valid_i (power_valid_b),
    .release_i     (scan_release),
    .rd_addr_i     (rd_addr),
    .rd_power_o    (rd_power_b),
    .frame_done_o  (frame_done_b),
    .peak_index_o  (peak_index_b_o),
    .peak_power_o  (peak_power_b_o)
  );

  // shared read address, one release for both
  diff_peak_scan u_scan (
    .clk_64m        (clk_64m),
    .rst            (rst),
    .done_a_i       (frame_done_a),
    .done_b_i       (frame_done_b),
    .rd_addr_o      (rd_addr),
    .power_a_i      (rd_power_a),
    .power_b_i      (rd_power_b),
    .release_o      (scan_release),
    .diff_index_o   (diff_index_o),
    .diff_power_o   (diff_power_o),
    .freq_word_o    (freq_word_o),
    .result_valid_o (result_valid_o)
  );

endmodule

`default_nettype wire

// ==== dv/spectral_diff_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module spectral_diff_checker (
  input  wire                               clk_64m,
  input  wire                               rst,
  input  wire  [spec_pkg::BIN_W-1:0]        peak_index_a_i,
  input  wire  [spec_pkg::POWER_W-1:0]      peak_power_a_i,
  input  wire  [spec_pkg::BIN_W-1:0]        peak_index_b_i,
  input  wire  [spec_pkg::POWER_W-1:0]      peak_power_b_i,
  input  wire  [spec_pkg::BIN_W-1:0]        diff_index_i,
  input  wire  [spec_pkg::POWER_W-1:0]      diff_power_i,
  input  wire  [spec_pkg::FREQ_W-1:0]       freq_word_i,
  input  wire                               result_valid_i
);

  localparam int FRAME_BINS = 2 * spec_pkg::HALF_BINS;
  localparam int NUM_FIELDS = 7;

  int error_count   = 0;
  int result_count  = 0;
  int missing_count = 0;
  int rst_cycles    = 0;

  // stimulus of the frame pairs that expect a result
  logic signed [spec_pkg::FFT_W-1:0] ref_re_a [FRAME_BINS];
  logic signed [spec_pkg::FFT_W-1:0] ref_im_a [FRAME_BINS];
  logic signed [spec_pkg::FFT_W-1:0] ref_re_b [FRAME_BINS];
  logic signed [spec_pkg::FFT_W-1:0] ref_im_b [FRAME_BINS];

  // one entry per frame pair, fields in field_name order
  logic [NUM_FIELDS-1:0][63:0] exp_q [$];
  logic [NUM_FIELDS-1:0][63:0] exp_v;
  logic [NUM_FIELDS-1:0][63:0] got_v;

  // ====================================================================
  // reference model
  // ====================================================================

  // re^2 + im^2, then the channel scale
  function automatic logic [63:0] bin_energy(input logic signed [spec_pkg::FFT_W-1:0] re,
                                             input logic signed [spec_pkg::FFT_W-1:0] im,
                                             input int shift);
    longint re_l;
    longint im_l;
    re_l = longint'(re);
    im_l = longint'(im);
    return (re_l * re_l + im_l * im_l) << shift;
  endfunction

  function automatic logic [NUM_FIELDS-1:0][63:0] reference_model();
    logic [NUM_FIELDS-1:0][63:0] res;
    logic [63:0] pa;
    logic [63:0] pb;
    logic [63:0] best_a;
    logic [63:0] best_b;
    logic [63:0] best_d;
    int          idx_a;
    int          idx_b;
    int          idx_d;
    int          freq;
    best_a = '0;
    best_b = '0;
    best_d = '0;
    idx_a  = 0;
    idx_b  = 0;
    idx_d  = 0;
    // only the lower half of the frame counts
    for (int i = 0; i < spec_pkg::HALF_BINS; i++) begin
      pa = bin_energy(ref_re_a[i], ref_im_a[i], 0);
      // channel b times four
      pb = bin_energy(ref_re_b[i], ref_im_b[i], 2);
      // open peak window, first maximum wins
      if (i > int'(spec_pkg::PEAK_LO) && i < int'(spec_pkg::PEAK_HI)) begin
        if (pa > best_a) begin
          best_a = pa;
          idx_a  = i;
        end
        if (pb > best_b) begin
          best_b = pb;
          idx_b  = i;
        end
      end
      // scan range ends one short of the buffer
      if (i < int'(spec_pkg::SCAN_END) && i > int'(spec_pkg::DIFF_LO) &&
          i < int'(spec_pkg::DIFF_HI) && pa > pb) begin
        if (pa - pb > best_d) begin
          best_d = pa - pb;
          idx_d  = i;
        end
      end
    end
    freq   = (idx_d >> spec_pkg::FREQ_SHIFT) * int'(spec_pkg::FREQ_STEP);
    res[0] = 64'(idx_a);
    res[1] = best_a;
    res[2] = 64'(idx_b);
    res[3] = best_b;
    res[4] = 64'(idx_d);
    res[5] = best_d;
    res[6] = 64'(freq[spec_pkg::FREQ_W-1:0]);
    return res;
  endfunction

  // ====================================================================
  // helpers called from the testbench top
  // ====================================================================

  task automatic set_bin(input int idx,
                         input logic signed [spec_pkg::FFT_W-1:0] ra,
                         input logic signed [spec_pkg::FFT_W-1:0] ia,
                         input logic signed [spec_pkg::FFT_W-1:0] rb,
                         input logic signed [spec_pkg::FFT_W-1:0] ib);
    ref_re_a[idx] = ra;
    ref_im_a[idx] = ia;
    ref_re_b[idx] = rb;
    ref_im_b[idx] = ib;
  endtask

  task automatic expect_frame();
    exp_q.push_back(reference_model());
  endtask

  function automatic int settled_count();
    return result_count + missing_count;
  endfunction

  function automatic string field_name(input int k);
    case (k)
      0:       return "peak_index_a";
      1:       return "peak_power_a";
      2:       return "peak_index_b";
      3:       return "peak_power_b";
      4:       return "diff_index";
      5:       return "diff_power";
      6:       return "freq_word";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic [NUM_FIELDS-1:0][63:0] observed();
    logic [NUM_FIELDS-1:0][63:0] res;
    res[0] = 64'(peak_index_a_i);
    res[1] = 64'(peak_power_a_i);
    res[2] = 64'(peak_index_b_i);
    res[3] = 64'(peak_power_b_i);
    res[4] = 64'(diff_index_i);
    res[5] = 64'(diff_power_i);
    res[6] = 64'(freq_word_i);
    return res;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      error_count++;
    end
  endtask

  // all results cleared, no strobe
  task automatic check_idle_outputs();
    logic [NUM_FIELDS-1:0][63:0] now_v;
    now_v = observed();
    for (int k = 0; k < NUM_FIELDS; k++) begin
      check_field(field_name(k), now_v[k], 64'd0);
    end
    check_field("result_valid", 64'(result_valid_i), 64'd0);
  endtask

  task automatic report_missing(input int frame_no);
    $display("no result_valid pulse arrived for frame pair %0d", frame_no);
    error_count++;
    missing_count++;
    if (exp_q.size() > 0) begin
      exp_q.delete(0);
    end
  endtask

  task automatic final_check();
    if (exp_q.size() > 0) begin
      $display("%0d expected results never arrived", exp_q.size());
      error_count = error_count + exp_q.size();
    end
  endtask

  // ====================================================================
  // compare, sampled mid cycle
  // ====================================================================

  always @(negedge clk_64m) begin
    if (rst) begin
      rst_cycles++;
      // registers clear on the first reset edge
      if (rst_cycles > 1) begin
        check_idle_outputs();
      end
    end else if (result_valid_i) begin
      result_count++;
      if (exp_q.size() == 0) begin
        $display("result_valid pulsed at %0t with no frame pair pending", $time);
        error_count++;
      end else begin
        exp_v = exp_q.pop_front();
        got_v = observed();
        for (int k = 0; k < NUM_FIELDS; k++) begin
          check_field(field_name(k), got_v[k], exp_v[k]);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_spectral_diff.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spectral_diff;

  localparam int FRAME_BINS       = 2 * spec_pkg::HALF_BINS;
  // frames driven over the whole run
  localparam int NUM_FRAMES       = 8;
  localparam int CYCLES_PER_FRAME = 7000;
  localparam int WATCHDOG_CYCLES  = NUM_FRAMES * CYCLES_PER_FRAME + 10000;
  // largest magnitude that still cannot overflow the scaled power
  localparam int HUGE_MAG         = (1 << 28) - 1;

  logic                               clk_64m;
  logic                               rst;
  logic signed [spec_pkg::FFT_W-1:0]  fft_real_a;
  logic signed [spec_pkg::FFT_W-1:0]  fft_imag_a;
  logic        [spec_pkg::BIN_W-1:0]  fft_index_a;
  logic                               fft_valid_a;
  logic signed [spec_pkg::FFT_W-1:0]  fft_real_b;
  logic signed [spec_pkg::FFT_W-1:0]  fft_imag_b;
  logic        [spec_pkg::BIN_W-1:0]  fft_index_b;
  logic                               fft_valid_b;
  logic        [spec_pkg::BIN_W-1:0]  peak_index_a;
  logic        [spec_pkg::POWER_W-1:0] peak_power_a;
  logic        [spec_pkg::BIN_W-1:0]  peak_index_b;
  logic        [spec_pkg::POWER_W-1:0] peak_power_b;
  logic        [spec_pkg::BIN_W-1:0]  diff_index;
  logic        [spec_pkg::POWER_W-1:0] diff_power;
  logic        [spec_pkg::FREQ_W-1:0] freq_word;
  logic                               result_valid;

  int seed;
  int expected_results;

  // frame under construction
  logic signed [spec_pkg::FFT_W-1:0] re_a [FRAME_BINS];
  logic signed [spec_pkg::FFT_W-1:0] im_a [FRAME_BINS];
  logic signed [spec_pkg::FFT_W-1:0] re_b [FRAME_BINS];
  logic signed [spec_pkg::FFT_W-1:0] im_b [FRAME_BINS];

  spectral_diff_top i_dut (
    .clk_64m        (clk_64m),
    .rst            (rst),
    .fft_real_a_i   (fft_real_a),
    .fft_imag_a_i   (fft_imag_a),
    .fft_index_a_i  (fft_index_a),
    .fft_valid_a_i  (fft_valid_a),
    .fft_real_b_i   (fft_real_b),
    .fft_imag_b_i   (fft_imag_b),
    .fft_index_b_i  (fft_index_b),
    .fft_valid_b_i  (fft_valid_b),
    .peak_index_a_o (peak_index_a),
    .peak_power_a_o (peak_power_a),
    .peak_index_b_o (peak_index_b),
    .peak_power_b_o (peak_power_b),
    .diff_index_o   (diff_index),
    .diff_power_o   (diff_power),
    .freq_word_o    (freq_word),
    .result_valid_o (result_valid)
  );

  spectral_diff_checker i_checker (
    .clk_64m        (clk_64m),
    .rst            (rst),
    .peak_index_a_i (peak_index_a),
    .peak_power_a_i (peak_power_a),
    .peak_index_b_i (peak_index_b),
    .peak_power_b_i (peak_power_b),
    .diff_index_i   (diff_index),
    .diff_power_i   (diff_power),
    .freq_word_i    (freq_word),
    .result_valid_i (result_valid)
  );

  initial begin
    clk_64m = 1'b0;
    forever #5 clk_64m = ~clk_64m;
  end

  // run length bound
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_64m);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // ====================================================================
  // frame construction
  // ====================================================================

  // signed value below 2^bits in magnitude
  function automatic logic signed [spec_pkg::FFT_W-1:0] rand_sample(input int bits);
    int r;
    r = $random(seed) % (1 << bits);
    return r[spec_pkg::FFT_W-1:0];
  endfunction

  task automatic fill_random(input int bits_a, input int bits_b);
    for (int i = 0; i < FRAME_BINS; i++) begin
      re_a[i] = rand_sample(bits_a);
      im_a[i] = rand_sample(bits_a);
      re_b[i] = rand_sample(bits_b);
      im_b[i] = rand_sample(bits_b);
    end
  endtask

  task automatic place_bin(input int idx, input int ra, input int ia, input int rb,
                           input int ib);
    re_a[idx] = ra[spec_pkg::FFT_W-1:0];
    im_a[idx] = ia[spec_pkg::FFT_W-1:0];
    re_b[idx] = rb[spec_pkg::FFT_W-1:0];
    im_b[idx] = ib[spec_pkg::FFT_W-1:0];
  endtask

  task automatic clear_frame();
    for (int i = 0; i < FRAME_BINS; i++) begin
      place_bin(i, 0, 0, 0, 0);
    end
  endtask

  // b equal to a, so scaled b is never below a
  task automatic mirror_a_to_b();
    for (int i = 0; i < FRAME_BINS; i++) begin
      re_b[i] = re_a[i];
      im_b[i] = im_a[i];
    end
  endtask

  // alternating sign, full scale in the unused half
  task automatic fill_upper_half();
    int huge;
    for (int i = spec_pkg::HALF_BINS; i < FRAME_BINS; i++) begin
      huge = (i % 2 == 0) ? HUGE_MAG : -HUGE_MAG;
      place_bin(i, huge, -huge, huge, huge);
    end
  endtask

  // ====================================================================
  // streaming and sequencing
  // ====================================================================

  task automatic share_frame();
    for (int i = 0; i < FRAME_BINS; i++) begin
      i_checker.set_bin(i, re_a[i], im_a[i], re_b[i], im_b[i]);
    end
    i_checker.expect_frame();
    expected_results++;
  endtask

  // both channels in lockstep, one bin per cycle
  task automatic send_frame();
    for (int i = 0; i < FRAME_BINS; i++) begin
      @(posedge clk_64m);
      fft_real_a  <= re_a[i];
      fft_imag_a  <= im_a[i];
      fft_index_a <= i[spec_pkg::BIN_W-1:0];
      fft_valid_a <= 1'b1;
      fft_real_b  <= re_b[i];
      fft_imag_b  <= im_b[i];
      fft_index_b <= i[spec_pkg::BIN_W-1:0];
      fft_valid_b <= 1'b1;
    end
  endtask

  task automatic end_stream();
    @(posedge clk_64m);
    fft_valid_a <= 1'b0;
    fft_valid_b <= 1'b0;
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    while (i_checker.settled_count() < expected_results && waited < CYCLES_PER_FRAME) begin
      @(posedge clk_64m);
      waited++;
    end
    if (i_checker.settled_count() < expected_results) begin
      i_checker.report_missing(expected_results);
    end
  endtask

  task automatic run_shared_frame();
    share_frame();
    send_frame();
    end_stream();
    wait_results();
  endtask

  initial begin
    seed             = 32'hff79;
    expected_results = 0;
    rst              = 1'b1;
    fft_real_a       = '0;
    fft_imag_a       = '0;
    fft_index_a      = '0;
    fft_valid_a      = 1'b0;
    fft_real_b       = '0;
    fft_imag_b       = '0;
    fft_index_b      = '0;
    fft_valid_b      = 1'b0;
    repeat (10) @(posedge clk_64m);
    rst <= 1'b0;
    // quiet after reset, nothing captured yet
    repeat (50) @(posedge clk_64m);
    @(negedge clk_64m);
    i_checker.check_idle_outputs();

    // random spectra
    repeat (3) begin
      fill_random(19, 18);
      run_shared_frame();
    end

    // guard windows, strongest bins sit just outside
    fill_random(8, 8);
    place_bin(2, 1 << 20, 0, 1 << 18, 0);
    place_bin(2045, 1 << 20, 0, 1 << 18, 0);
    place_bin(9, 1 << 18, 0, 0, 0);
    place_bin(3, 0, 0, 1 << 17, 0);
    place_bin(4, 3 << 17, 0, 1 << 16, 0);
    place_bin(11, 1 << 17, 0, 0, 0);
    run_shared_frame();

    // b dominates every bin
    fill_random(16, 16);
    mirror_a_to_b();
    run_shared_frame();

    // equal maxima, lower index expected
    clear_frame();
    place_bin(100, 1000, 0, 0, 0);
    place_bin(200, 0, 1000, 0, 0);
    place_bin(300, 0, 0, 500, 0);
    place_bin(400, 0, 0, 0, 500);
    run_shared_frame();

    // huge upper half, then a second frame during the scan
    fill_random(19, 18);
    fill_upper_half();
    share_frame();
    send_frame();
    fill_random(19, 18);
    send_frame();
    end_stream();
    wait_results();
    // a captured second frame would report here
    repeat (3000) @(posedge clk_64m);

    i_checker.final_check();
    $display("run complete: %0d results checked, %0d errors",
             i_checker.result_count, i_checker.error_count);
    if (i_checker.error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/spec_pkg.sv
hdl/bin_power.sv
hdl/frame_capture.sv
hdl/diff_peak_scan.sv
hdl/spectral_diff_top.sv
dv/spectral_diff_checker.sv
dv/tb_spectral_diff.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the spectral difference testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_spectral_diff \
  -f verilog.f

./obj_dir/Vtb_spectral_diff > sim.log 2>&1
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
  echo "simulation result: pass"
  exit 0
fi

echo "simulation result: fail, see sim.log"
exit 1
